// File: source/me_pixel_pkg.sv
package me_pixel_pkg;

    // Block geometry
    localparam int BLOCK_DIM = 8;                       // Pixels per row, rows per block
    localparam int WORD_PIX = 4;                        // Pixels per load word
    localparam int BLOCK_WORDS = BLOCK_DIM * BLOCK_DIM / WORD_PIX;

    // One unsigned luma sample
    typedef logic [7:0] pixel_t;

    // Load word, pixel 0 in the low byte
    typedef pixel_t [WORD_PIX-1:0] pixel_word_t;

    typedef pixel_t [BLOCK_DIM-1:0] block_row_t;        // Pixel 0 low

    // Whole block with row 0 in the low bits
    typedef block_row_t [BLOCK_DIM-1:0] block_t;

endpackage

// File: source/me_search_pkg.sv
package me_search_pkg;

    localparam int SAD_W = 14;                          // Holds 64 * 255
    localparam int IDX_W = 8;

    typedef logic [SAD_W-1:0] sad_t;

    // Candidate number within a search
    typedef struct packed {
        logic [IDX_W-1:0] idx;
        logic             last;                         // Final candidate of the search
    } cand_tag_t;

    // Best match reported at the end of a search
    typedef struct packed {
        sad_t             best_sad;
        logic [IDX_W-1:0] best_idx;
    } match_result_t;

endpackage

// File: source/cur_block_buffer.sv
`timescale 1ns/1ps

module cur_block_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  logic [3:0]                wr_word,
    input  me_pixel_pkg::pixel_word_t cur_word,
    input  logic                      next_block,
    output me_pixel_pkg::block_t      cur_blk
);

    import me_pixel_pkg::*;

    block_t store [2];          // Two halves, 128 pixels

    logic       half;           // Active half
    logic       wr_half;
    logic       in_hand;
    logic [2:0] hand_cnt;

    // A word written in the flip cycle already goes to the half that is
    // about to become inactive
    assign wr_half = next_block ? half : ~half;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int p = 0; p < WORD_PIX; p++) begin
                store[wr_half][wr_word[3:1]][wr_word[0] * WORD_PIX + p] <= cur_word[p];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half     <= 1'b0;
            in_hand  <= 1'b0;
            hand_cnt <= '0;
        end else if (next_block) begin
            half     <= ~half;
            in_hand  <= 1'b1;
            hand_cnt <= '0;
        end else if (in_hand) begin
            hand_cnt <= hand_cnt + 3'd1;
            if (hand_cnt == 3'(BLOCK_DIM - 1)) begin
                in_hand <= 1'b0;
            end
        end
    end

    // Rows 0..hand_cnt already show the new block, the rest still the old one.
    // The output register adds the cycle that lines row r up with SAD stage r
    always_ff @(posedge clk) begin
        for (int r = 0; r < BLOCK_DIM; r++) begin
            if (!in_hand || r <= hand_cnt) begin
                cur_blk[r] <= store[half][r];
            end else begin
                cur_blk[r] <= store[~half][r];
            end
        end
    end

    // Control must wait for the row skew to drain before the next flip
    a_no_flip_in_handover : assert property (
        @(posedge clk) disable iff (rst) next_block |-> !in_hand
    ) else $error("next_block during handover");

endmodule

// File: source/me_block_ctrl.sv
`timescale 1ns/1ps

module me_block_ctrl #(
    parameter int NUM_CAND = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cur_wr,
    input  logic                    block_start,
    input  logic                    ref_valid,
    input  me_pixel_pkg::block_t    ref_blk,
    output logic                    wr_en,
    output logic [3:0]              wr_word,
    output logic                    load_done,
    output logic                    next_block,
    output logic                    cand_valid,
    output me_pixel_pkg::block_t    cand_blk,
    output me_search_pkg::cand_tag_t cand_tag
);

    import me_pixel_pkg::*;
    import me_search_pkg::*;

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_CAND - 1);

    logic [3:0]       load_cnt;
    logic [IDX_W-1:0] cand_idx;
    cand_tag_t        tag_d;

    assign wr_en   = cur_wr && !load_done;   // Full block ignores extra words
    assign wr_word = load_cnt;

    assign tag_d.idx  = cand_idx;
    assign tag_d.last = (cand_idx == LAST_IDX);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_cnt   <= '0;
            load_done  <= 1'b0;
            next_block <= 1'b0;
            cand_idx   <= '0;
            cand_valid <= 1'b0;
        end else begin
            next_block <= block_start;
            cand_valid <= ref_valid;

            if (block_start) begin
                load_cnt  <= '0;
                load_done <= 1'b0;
            end else if (wr_en) begin
                load_cnt <= load_cnt + 4'd1;
                if (load_cnt == 4'(BLOCK_WORDS - 1)) begin
                    load_done <= 1'b1;
                end
            end

            // New search numbering starts with the next candidate
            if (block_start) begin
                cand_idx <= '0;
            end else if (ref_valid) begin
                cand_idx <= tag_d.last ? '0 : cand_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ref_valid) begin
            cand_blk <= ref_blk;
            cand_tag <= tag_d;
        end
    end

    a_start_when_loaded : assert property (
        @(posedge clk) disable iff (rst) block_start |-> load_done
    ) else $error("block_start before the next block is loaded");

endmodule

// File: source/sad_engine.sv
`timescale 1ns/1ps

module sad_engine (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cand_valid,
    input  me_pixel_pkg::block_t     cand_blk,
    input  me_search_pkg::cand_tag_t cand_tag,
    input  me_pixel_pkg::block_t     cur_blk,
    output logic                     sad_valid,
    output me_search_pkg::sad_t      sad,
    output me_search_pkg::cand_tag_t sad_tag
);

    import me_pixel_pkg::*;
    import me_search_pkg::*;

    logic                 in_valid;
    block_t               in_blk;
    cand_tag_t            in_tag;
    logic [BLOCK_DIM-1:0] valid_q;
    sad_t                 sum_q [BLOCK_DIM];
    cand_tag_t            tag_q [BLOCK_DIM];
    block_t               blk_q [BLOCK_DIM-1];     // Candidate rows still to be used

    function automatic sad_t row_sad(block_row_t a, block_row_t b);
        sad_t   acc;
        pixel_t diff;
        acc = '0;
        for (int i = 0; i < BLOCK_DIM; i++) begin
            diff = (a[i] > b[i]) ? a[i] - b[i] : b[i] - a[i];
            acc  = acc + sad_t'(diff);
        end
        return acc;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_valid <= 1'b0;
            valid_q  <= '0;
        end else begin
            in_valid <= cand_valid;
            valid_q  <= {valid_q[BLOCK_DIM-2:0], in_valid};
        end
    end

    // Input register, stage r then meets row r one cycle after its handover step
    always_ff @(posedge clk) begin
        in_blk <= cand_blk;
        in_tag <= cand_tag;
    end

    // Stage r compares row r against cur_blk row r as it is in that cycle
    always_ff @(posedge clk) begin
        sum_q[0] <= row_sad(in_blk[0], cur_blk[0]);
        tag_q[0] <= in_tag;
        blk_q[0] <= in_blk;
        for (int r = 1; r < BLOCK_DIM; r++) begin
            sum_q[r] <= sum_q[r-1] + row_sad(blk_q[r-1][r], cur_blk[r]);
            tag_q[r] <= tag_q[r-1];
        end
        for (int r = 1; r < BLOCK_DIM - 1; r++) begin
            blk_q[r] <= blk_q[r-1];
        end
    end

    assign sad_valid = valid_q[BLOCK_DIM-1];
    assign sad       = sum_q[BLOCK_DIM-1];
    assign sad_tag   = tag_q[BLOCK_DIM-1];

endmodule

// File: source/best_match.sv
`timescale 1ns/1ps

module best_match (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         sad_valid,
    input  me_search_pkg::sad_t          sad,
    input  me_search_pkg::cand_tag_t     sad_tag,
    output me_search_pkg::match_result_t result,
    output logic                         result_valid
);

    import me_search_pkg::*;

    logic          have_min;    // A candidate of this search was seen
    logic          take;
    match_result_t min_q;
    match_result_t next_min;

    // Strict compare keeps the earlier candidate on a tie
    always_comb begin
        take = !have_min || (sad < min_q.best_sad);
        next_min.best_sad = take ? sad : min_q.best_sad;
        next_min.best_idx = take ? sad_tag.idx : min_q.best_idx;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            have_min     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= sad_valid && sad_tag.last;
            if (sad_valid) begin
                have_min <= !sad_tag.last;    // Restart after the last one
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sad_valid) begin
            min_q <= next_min;
            if (sad_tag.last) begin
                result <= next_min;
            end
        end
    end

    a_valid_known : assert property (
        @(posedge clk) disable iff (rst) !$isunknown(sad_valid)
    ) else $error("sad_valid unknown");

endmodule

// File: source/me_top.sv
`timescale 1ns/1ps

module me_top #(
    parameter int NUM_CAND = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  me_pixel_pkg::pixel_word_t    cur_word,
    input  logic                         cur_wr,
    input  logic                         block_start,
    input  me_pixel_pkg::block_t         ref_blk,
    input  logic                         ref_valid,
    output logic                         load_done,
    output me_search_pkg::match_result_t result,
    output logic                         result_valid
);

    import me_pixel_pkg::*;
    import me_search_pkg::*;

    logic       wr_en;
    logic [3:0] wr_word;
    logic       next_block;
    logic       cand_valid;
    logic       sad_valid;
    block_t     cur_blk;
    block_t     cand_blk;
    cand_tag_t  cand_tag;
    cand_tag_t  sad_tag;
    sad_t       sad;

    me_block_ctrl #(.NUM_CAND(NUM_CAND)) u_ctrl (
        .clk, .rst, .cur_wr, .block_start, .ref_valid, .ref_blk,
        .wr_en, .wr_word, .load_done, .next_block,
        .cand_valid, .cand_blk, .cand_tag
    );

    cur_block_buffer u_buf (
        .clk, .rst, .wr_en, .wr_word, .cur_word, .next_block, .cur_blk
    );

    sad_engine u_sad (
        .clk, .rst, .cand_valid, .cand_blk, .cand_tag, .cur_blk,
        .sad_valid, .sad, .sad_tag
    );

    best_match u_best (
        .clk, .rst, .sad_valid, .sad, .sad_tag, .result, .result_valid
    );

endmodule

// File: sim/me_tb.sv
`timescale 1ns/1ps

module me_tb;

    import me_pixel_pkg::*;
    import me_search_pkg::*;

    localparam int NUM_CAND = 16;
    localparam int CLK_PERIOD = 20;
    localparam int SEED = 63;
    localparam int RESULT_LAT = 10;                 // Last ref_valid sample to result_valid
    localparam int WAIT_MAX = 4 * RESULT_LAT;
    localparam int WORDS_PER_ROW = BLOCK_DIM / WORD_PIX;
    // Two loads, idle cycles and six searches
    localparam int TEST_CYCLES = 2 * BLOCK_WORDS + 16 + 6 * (NUM_CAND + WAIT_MAX);
    localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

    logic          clk;
    logic          rst;
    pixel_word_t   cur_word;
    logic          cur_wr;
    logic          block_start;
    block_t        ref_blk;
    logic          ref_valid;
    logic          load_done;
    match_result_t result;
    logic          result_valid;

    int            errors = 0;
    int            checks = 0;
    int            cyc = 0;                         // Number of the last rising edge
    int            seed_val;
    match_result_t res_q[$];
    int            res_cyc_q[$];
    block_t        cand_q[$];                       // Every candidate offered
    block_t        cur_q[$];                        // Current block it is compared with
    block_t        model_cur;
    block_t        blk_a;
    block_t        blk_c;

    me_top #(.NUM_CAND(NUM_CAND)) u_dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    always @(negedge clk) begin
        if (result_valid === 1'b1) begin
            res_q.push_back(result);
            res_cyc_q.push_back(cyc);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    function automatic block_t rand_block();
        block_t b;
        for (int r = 0; r < BLOCK_DIM; r++) begin
            for (int p = 0; p < BLOCK_DIM; p++) begin
                b[r][p] = pixel_t'($urandom);
            end
        end
        return b;
    endfunction

    function automatic int block_sad(input block_t a, input block_t b);
        int acc;
        int d;
        acc = 0;
        for (int r = 0; r < BLOCK_DIM; r++) begin
            for (int p = 0; p < BLOCK_DIM; p++) begin
                d = int'(a[r][p]) - int'(b[r][p]);
                acc += (d < 0) ? -d : d;
            end
        end
        return acc;
    endfunction

    // Strict minimum over one search, first candidate wins a tie
    function automatic match_result_t expected_best(input int first);
        match_result_t best;
        int            s;
        int            min_s;
        best  = '0;
        min_s = -1;
        for (int i = 0; i < NUM_CAND; i++) begin
            s = block_sad(cand_q[first + i], cur_q[first + i]);
            if (min_s < 0 || s < min_s) begin
                min_s = s;
                best.best_sad = sad_t'(s);
                best.best_idx = 8'(i);
            end
        end
        return best;
    endfunction

    task automatic load_block(input block_t b, input logic check_fill);
        for (int w = 0; w < BLOCK_WORDS; w++) begin
            for (int p = 0; p < WORD_PIX; p++) begin
                cur_word[p] = b[w / WORDS_PER_ROW][(w % WORDS_PER_ROW) * WORD_PIX + p];
            end
            cur_wr = 1'b1;
            if (check_fill) begin
                check_value("load_done", 0, load_done);
            end
            @(negedge clk);
        end
        cur_wr = 1'b0;
        if (check_fill) begin
            check_value("load_done", 1, load_done);
        end
    endtask

    // One candidate for one cycle, edge_no is the edge that samples it
    task automatic offer_cand(input block_t b, input logic start, output int edge_no);
        ref_blk     = b;
        ref_valid   = 1'b1;
        block_start = start;
        edge_no     = cyc + 1;
        cand_q.push_back(b);
        cur_q.push_back(model_cur);
        @(negedge clk);
        ref_valid   = 1'b0;
        block_start = 1'b0;
    endtask

    task automatic check_search(input int first, input int last_edge,
                                output match_result_t got);
        match_result_t exp;
        int            res_cyc;
        int            waited;
        exp    = expected_best(first);
        got    = '0;
        waited = 0;
        while (res_q.size() == 0 && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (res_q.size() > 0) else begin
            errors++;
            $display("No result_valid pulse for the search starting at candidate %0d", first);
        end
        if (res_q.size() > 0) begin
            got     = res_q.pop_front();
            res_cyc = res_cyc_q.pop_front();
            check_value("result.best_sad", exp.best_sad, got.best_sad);
            check_value("result.best_idx", exp.best_idx, got.best_idx);
            checks++;
            assert (res_cyc - last_edge == RESULT_LAT) else begin
                errors++;
                $display("result_valid came %0d cycles after the last candidate, not %0d",
                         res_cyc - last_edge, RESULT_LAT);
            end
        end
    endtask

    task automatic test_reset_load();
        check_value("load_done", 0, load_done);
        check_value("result_valid", 0, result_valid);
        blk_a = rand_block();
        load_block(blk_a, 1'b1);
        cur_word = pixel_word_t'($urandom);         // Extra word must be dropped
        cur_wr   = 1'b1;
        @(negedge clk);
        cur_wr = 1'b0;
        check_value("load_done", 1, load_done);
    endtask

    task automatic test_single_search();
        int            first;
        int            edge_no;
        match_result_t got;
        block_start = 1'b1;
        @(negedge clk);
        block_start = 1'b0;
        model_cur   = blk_a;
        repeat (BLOCK_DIM + 4) @(negedge clk);     // Handover done
        first = cand_q.size();
        for (int i = 0; i < NUM_CAND; i++) begin
            offer_cand(rand_block(), 1'b0, edge_no);
        end
        check_search(first, edge_no, got);
    endtask

    task automatic test_ties();
        int            first;
        int            edge_no;
        match_result_t got;
        block_t        near;
        near       = blk_a;
        near[3][5] = near[3][5] ^ 8'h01;            // SAD of exactly 1
        first      = cand_q.size();
        for (int i = 0; i < NUM_CAND; i++) begin
            offer_cand((i == 4 || i == 11) ? near : rand_block(), 1'b0, edge_no);
        end
        check_search(first, edge_no, got);
        check_value("result.best_idx", 4, got.best_idx);
        check_value("result.best_sad", 1, got.best_sad);
    endtask

    task automatic test_ping_pong();
        int            first_old;
        int            first_new;
        int            old_edge;
        int            edge_no;
        match_result_t got;
        blk_c     = rand_block();
        first_old = cand_q.size();
        fork
            load_block(blk_c, 1'b0);
            begin
                @(negedge clk);
                for (int i = 0; i < NUM_CAND - 1; i++) begin
                    offer_cand(rand_block(), 1'b0, edge_no);
                end
            end
        join
        check_value("load_done", 1, load_done);
        // Last old candidate shares its cycle with block_start
        offer_cand(blk_a, 1'b1, old_edge);
        model_cur = blk_c;
        first_new = cand_q.size();
        for (int i = 0; i < NUM_CAND; i++) begin
            offer_cand((i == 0) ? blk_c : rand_block(), 1'b0, edge_no);
        end
        check_search(first_old, old_edge, got);
        check_value("result.best_idx", NUM_CAND - 1, got.best_idx);
        check_value("result.best_sad", 0, got.best_sad);
        check_search(first_new, edge_no, got);
        check_value("result.best_idx", 0, got.best_idx);
        check_value("result.best_sad", 0, got.best_sad);
    endtask

    task automatic test_back_to_back();
        int            first;
        int            mid_edge;
        int            edge_no;
        match_result_t got;
        first    = cand_q.size();
        mid_edge = 0;
        for (int i = 0; i < 2 * NUM_CAND; i++) begin
            offer_cand(rand_block(), 1'b0, edge_no);
            if (i == NUM_CAND - 1) begin
                mid_edge = edge_no;
            end
        end
        check_search(first, mid_edge, got);
        check_search(first + NUM_CAND, edge_no, got);
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        #(WATCHDOG_NS);
        errors++;
        $display("Watchdog expired before the tests finished");
        finish_run();
    end

    initial begin
        seed_val    = $urandom(SEED);
        rst         = 1'b1;
        cur_word    = '0;
        cur_wr      = 1'b0;
        block_start = 1'b0;
        ref_blk     = '0;
        ref_valid   = 1'b0;
        model_cur   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset_load();
        test_single_search();
        test_ties();
        test_ping_pong();
        test_back_to_back();
        repeat (4) @(negedge clk);
        checks++;
        assert (res_q.size() == 0) else begin
            errors++;
            $display("Found %0d result_valid pulses that no search asked for", res_q.size());
        end
        finish_run();
    end

endmodule

// File: all.f
source/me_pixel_pkg.sv
source/me_search_pkg.sv
source/cur_block_buffer.sv
source/me_block_ctrl.sv
source/sad_engine.sv
source/best_match.sv
source/me_top.sv
sim/me_tb.sv

// File: Bender.yml
package:
  name: me_core

sources:
  - source/me_pixel_pkg.sv
  - source/me_search_pkg.sv
  - source/cur_block_buffer.sv
  - source/me_block_ctrl.sv
  - source/sad_engine.sv
  - source/best_match.sv
  - source/me_top.sv
  - target: test
    files:
      - sim/me_tb.sv
